/* rtl/icache_config.svh */
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// physical byte address width
`define ICACHE_ADDR_W 16

// fetch word returned to the cpu
`define ICACHE_WORD_W 32

// one cache line, four fetch words
`define ICACHE_LINE_W 128

// associativity and number of sets
`define ICACHE_WAYS 4
`define ICACHE_SETS 16

// random replacement source
`define ICACHE_LFSR_W 8

`endif

/* rtl/icache_pkg.sv */
`include "icache_config.svh"

package icache_pkg;

  // address split, tag | index | byte offset
  localparam int unsigned OFFSET_W = $clog2(`ICACHE_LINE_W / 8);
  localparam int unsigned INDEX_W  = $clog2(`ICACHE_SETS);
  localparam int unsigned TAG_W    = `ICACHE_ADDR_W - INDEX_W - OFFSET_W;
  localparam int unsigned WAY_W    = $clog2(`ICACHE_WAYS);
  // word number inside a line
  localparam int unsigned WSEL_W   = $clog2(`ICACHE_LINE_W / `ICACHE_WORD_W);

  typedef logic [TAG_W-1:0]          tag_t;
  typedef logic [INDEX_W-1:0]        index_t;
  typedef logic [OFFSET_W-1:0]       offset_t;
  typedef logic [WAY_W-1:0]          way_idx_t;
  typedef logic [`ICACHE_WAYS-1:0]   way_vec_t;
  typedef logic [`ICACHE_LINE_W-1:0] line_t;
  typedef logic [`ICACHE_WORD_W-1:0] word_t;

  typedef struct packed {
    tag_t    tag;
    index_t  index;
    offset_t offset;
  } fetch_fields_t;

  // raw word for the refill address, fields for the array lookup
  typedef union packed {
    logic [`ICACHE_ADDR_W-1:0] raw;
    fetch_fields_t             f;
  } fetch_addr_u;

  typedef enum logic [2:0] {FLUSH, IDLE, LOOKUP, REFILL, REFILL_DONE} state_e;

endpackage

/* rtl/icache_ctrl.sv */
`timescale 1ns/1ps

`include "icache_config.svh"

module icache_ctrl import icache_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      en_i,
  input  logic                      flush_i,
  input  logic                      fetch_req_i,
  input  fetch_addr_u               fetch_addr_i,
  output logic                      fetch_ack_o,
  output logic                      refill_req_o,
  output logic [`ICACHE_ADDR_W-1:0] refill_addr_o,
  input  logic                      refill_ack_i,
  input  way_vec_t                  way_hit_i,
  input  logic                      flush_done_i,
  output fetch_addr_u               lookup_addr_o,
  output logic                      flush_en_o,
  output logic                      fill_en_o,
  output logic                      use_refill_o,
  output logic                      miss_o
);

  state_e      state_d, state_q;
  logic        cache_en_d, cache_en_q;
  logic        flush_d, flush_q;
  logic        ack_d, ack_q;
  // current fetch is answered from the captured refill line
  logic        held_d, held_q;
  fetch_addr_u addr_d, addr_q;
  // first cycle of the refill ack
  logic        line_taken;

  assign line_taken    = (state_q == REFILL) && refill_ack_i;
  assign fetch_ack_o   = ack_q;
  assign refill_req_o  = (state_q == REFILL);
  // line aligned, built from the raw address word
  assign refill_addr_o = {addr_q.raw[`ICACHE_ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
  assign lookup_addr_o = addr_q;
  assign flush_en_o    = (state_q == FLUSH);
  // write the line only while the cache is on
  assign fill_en_o     = line_taken && cache_en_q;
  // disabled fetches are refills too, but no misses
  assign miss_o        = line_taken && cache_en_q;
  assign use_refill_o  = line_taken || held_q;

  //////////////////////////////////////////////////
  // control fsm
  //////////////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    // disabling is immediate, enabling goes via flush
    cache_en_d = cache_en_q & en_i;
    flush_d    = flush_q | flush_i;
    ack_d      = ack_q;
    held_d     = held_q;
    addr_d     = addr_q;
    unique case (state_q)
      // walk all sets, then take the enable
      FLUSH: begin
        if (flush_done_i) begin
          state_d    = IDLE;
          flush_d    = flush_i;
          cache_en_d = en_i;
        end
      end
      // finish the open handshake first, then flush or a new fetch
      IDLE: begin
        if (ack_q) begin
          if (!fetch_req_i) begin
            ack_d  = 1'b0;
            held_d = 1'b0;
          end
        end else if (flush_q || (en_i && !cache_en_q)) begin
          state_d = FLUSH;
        end else if (fetch_req_i) begin
          addr_d  = fetch_addr_i;
          state_d = LOOKUP;
        end
      end
      // tags of the captured index are compared here
      LOOKUP: begin
        if (cache_en_q && (|way_hit_i)) begin
          ack_d   = 1'b1;
          state_d = IDLE;
        end else begin
          state_d = REFILL;
        end
      end
      // line is captured on the first ack cycle
      REFILL: begin
        if (refill_ack_i) begin
          held_d  = 1'b1;
          state_d = REFILL_DONE;
        end
      end
      // memory must release its ack before the fetch is answered
      REFILL_DONE: begin
        if (!refill_ack_i) begin
          ack_d   = 1'b1;
          state_d = IDLE;
        end
      end
      default: begin
        state_d = FLUSH;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= FLUSH;
      cache_en_q <= 1'b0;
      flush_q    <= 1'b0;
      ack_q      <= 1'b0;
      held_q     <= 1'b0;
      addr_q     <= '0;
    end else begin
      state_q    <= state_d;
      cache_en_q <= cache_en_d;
      flush_q    <= flush_d;
      ack_q      <= ack_d;
      held_q     <= held_d;
      addr_q     <= addr_d;
    end
  end

endmodule

/* rtl/icache_tag_array.sv */
`timescale 1ns/1ps

`include "icache_config.svh"

module icache_tag_array import icache_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  fetch_addr_u lookup_addr_i,
  input  logic        flush_en_i,
  output logic        flush_done_o,
  input  logic        inv_valid_i,
  input  index_t      inv_index_i,
  input  logic        fill_en_i,
  input  way_idx_t    victim_way_i,
  output way_vec_t    way_hit_o,
  output way_vec_t    valid_vec_o,
  output way_idx_t    hit_idx_o
);

  tag_t     tag_q   [`ICACHE_SETS][`ICACHE_WAYS];
  way_vec_t valid_q [`ICACHE_SETS];
  index_t   flush_cnt_q;
  index_t   idx;

  assign idx = lookup_addr_i.f.index;

  //////////////////////////////////////////////////
  // flush walk and valid bits
  //////////////////////////////////////////////////

  // one set per cycle, wraps to zero after the last set
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flush_cnt_q <= '0;
    end else if (flush_en_i) begin
      flush_cnt_q <= flush_cnt_q + 1'b1;
    end
  end

  assign flush_done_o = flush_en_i && (flush_cnt_q == index_t'(`ICACHE_SETS - 1));

  // flush beats invalidation, fills never overlap either
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '{default: '0};
    end else if (flush_en_i) begin
      valid_q[flush_cnt_q] <= '0;
    end else if (inv_valid_i) begin
      // whole set goes, all ways
      valid_q[inv_index_i] <= '0;
    end else if (fill_en_i) begin
      valid_q[idx][victim_way_i] <= 1'b1;
    end
  end

  // tag storage
  always_ff @(posedge clk_i) begin
    if (fill_en_i) begin
      tag_q[idx][victim_way_i] <= lookup_addr_i.f.tag;
    end
  end

  //////////////////////////////////////////////////
  // tag compare, hit generation
  //////////////////////////////////////////////////

  assign valid_vec_o = valid_q[idx];

  for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : gen_cmp
    assign way_hit_o[w] = valid_q[idx][w] && (tag_q[idx][w] == lookup_addr_i.f.tag);
  end

  // binary way number of the hit, lowest way wins
  always_comb begin
    hit_idx_o = '0;
    for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
      if (way_hit_o[w]) begin
        hit_idx_o = way_idx_t'(w);
      end
    end
  end

endmodule

/* rtl/icache_data_array.sv */
`timescale 1ns/1ps

`include "icache_config.svh"

module icache_data_array import icache_pkg::*; (
  input  logic        clk_i,
  input  fetch_addr_u lookup_addr_i,
  input  logic        fill_en_i,
  input  way_idx_t    victim_way_i,
  input  line_t       refill_line_i,
  input  way_idx_t    hit_idx_i,
  input  logic        use_refill_i,
  output word_t       fetch_data_o
);

  line_t             mem_q [`ICACHE_SETS][`ICACHE_WAYS];
  // copy of the last refill line, outlives the memory ack
  line_t             line_q;
  logic              use_refill_q;
  line_t             src_line;
  logic [WSEL_W-1:0] wsel;

  always_ff @(posedge clk_i) begin
    // refill goes to the chosen victim of the looked up set
    if (fill_en_i) begin
      mem_q[lookup_addr_i.f.index][victim_way_i] <= refill_line_i;
    end
    // capture on the first cycle of the refill select
    if (use_refill_i && !use_refill_q) begin
      line_q <= refill_line_i;
    end
    use_refill_q <= use_refill_i;
  end

  // word number from the upper offset bits
  assign wsel = lookup_addr_i.f.offset[OFFSET_W-1 -: WSEL_W];

  // misses and disabled fetches read the captured line
  assign src_line = use_refill_i ? line_q : mem_q[lookup_addr_i.f.index][hit_idx_i];

  assign fetch_data_o = src_line[wsel * `ICACHE_WORD_W +: `ICACHE_WORD_W];

endmodule

/* rtl/icache_repl.sv */
`timescale 1ns/1ps

`include "icache_config.svh"

module icache_repl import icache_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  way_vec_t valid_vec_i,
  input  logic     fill_en_i,
  output way_idx_t victim_way_o
);

  // x^8 + x^6 + x^5 + x^4 + 1, galois form
  localparam logic [`ICACHE_LFSR_W-1:0] LFSR_TAPS = 'hB8;
  localparam logic [`ICACHE_LFSR_W-1:0] LFSR_SEED = 'h01;

  logic [`ICACHE_LFSR_W-1:0] lfsr_q;
  way_idx_t                  inv_way;
  logic                      all_valid;

  assign all_valid = &valid_vec_i;

  // lowest numbered free way
  always_comb begin
    inv_way = '0;
    for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
      if (!valid_vec_i[w]) begin
        inv_way = way_idx_t'(w);
      end
    end
  end

  // steps only when a full set really evicts something
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= LFSR_SEED;
    end else if (fill_en_i && all_valid) begin
      lfsr_q <= {1'b0, lfsr_q[`ICACHE_LFSR_W-1:1]} ^ (lfsr_q[0] ? LFSR_TAPS : '0);
    end
  end

  // free way first, random pick once the set is full
  assign victim_way_o = all_valid ? lfsr_q[WAY_W-1:0] : inv_way;

endmodule

/* rtl/icache_top.sv */
`timescale 1ns/1ps

`include "icache_config.svh"

module icache_top import icache_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      en_i,
  input  logic                      flush_i,
  // cpu fetch port
  input  logic                      fetch_req_i,
  input  fetch_addr_u               fetch_addr_i,
  output logic                      fetch_ack_o,
  output word_t                     fetch_data_o,
  // memory refill port
  output logic                      refill_req_o,
  output logic [`ICACHE_ADDR_W-1:0] refill_addr_o,
  input  logic                      refill_ack_i,
  input  line_t                     refill_line_i,
  // set invalidation from memory side
  input  logic                      inv_valid_i,
  input  index_t                    inv_index_i,
  output logic                      miss_o
);

  fetch_addr_u lookup_addr;
  logic        flush_en;
  logic        flush_done;
  logic        fill_en;
  logic        use_refill;
  way_vec_t    way_hit;
  way_vec_t    valid_vec;
  way_idx_t    hit_idx;
  way_idx_t    victim_way;

  icache_ctrl u_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .en_i          (en_i),
    .flush_i       (flush_i),
    .fetch_req_i   (fetch_req_i),
    .fetch_addr_i  (fetch_addr_i),
    .fetch_ack_o   (fetch_ack_o),
    .refill_req_o  (refill_req_o),
    .refill_addr_o (refill_addr_o),
    .refill_ack_i  (refill_ack_i),
    .way_hit_i     (way_hit),
    .flush_done_i  (flush_done),
    .lookup_addr_o (lookup_addr),
    .flush_en_o    (flush_en),
    .fill_en_o     (fill_en),
    .use_refill_o  (use_refill),
    .miss_o        (miss_o)
  );

  icache_tag_array u_tags (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .lookup_addr_i (lookup_addr),
    .flush_en_i    (flush_en),
    .flush_done_o  (flush_done),
    .inv_valid_i   (inv_valid_i),
    .inv_index_i   (inv_index_i),
    .fill_en_i     (fill_en),
    .victim_way_i  (victim_way),
    .way_hit_o     (way_hit),
    .valid_vec_o   (valid_vec),
    .hit_idx_o     (hit_idx)
  );

  icache_data_array u_data (
    .clk_i         (clk_i),
    .lookup_addr_i (lookup_addr),
    .fill_en_i     (fill_en),
    .victim_way_i  (victim_way),
    .refill_line_i (refill_line_i),
    .hit_idx_i     (hit_idx),
    .use_refill_i  (use_refill),
    .fetch_data_o  (fetch_data_o)
  );

  icache_repl u_repl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .valid_vec_i  (valid_vec),
    .fill_en_i    (fill_en),
    .victim_way_o (victim_way)
  );

endmodule

/* verif/icache_chk.sv */
`timescale 1ns/1ps

module icache_chk import icache_pkg::*; (
  input logic     clk_i,
  input logic     rst_ni,
  input logic     fetch_req_i,
  input logic     fetch_ack_i,
  input logic     refill_req_i,
  input logic     refill_ack_i,
  input way_vec_t way_hit_i
);

  // failed assertions, read by the testbench summary
  int fail_cnt = 0;

  //////////////////////////////////////////////////
  // handshake rules
  //////////////////////////////////////////////////

  // ack answers a live request, or one released a cycle ago
  ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_ack_i |-> (fetch_req_i || $past(fetch_req_i)))
    else begin
      $error("fetch ack seen without a fetch request");
      fail_cnt++;
    end

  // refill request is held until memory answers
  refill_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (refill_req_i && !refill_ack_i) |=> refill_req_i)
    else begin
      $error("refill request dropped before its ack");
      fail_cnt++;
    end

  // a tag can live in one way of a set only
  hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(way_hit_i))
    else begin
      $error("more than one way hit");
      fail_cnt++;
    end

endmodule

bind icache_top icache_chk u_chk (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .fetch_req_i  (fetch_req_i),
  .fetch_ack_i  (fetch_ack_o),
  .refill_req_i (refill_req_o),
  .refill_ack_i (refill_ack_i),
  .way_hit_i    (way_hit)
);

/* verif/icache_tb.sv */
`timescale 1ns/1ps

`include "icache_config.svh"

module icache_tb import icache_pkg::*; ();

  typedef enum logic [2:0] {OP_FETCH, OP_FLUSH, OP_INV, OP_EN, OP_DIS, OP_BOUND} op_e;

  // operation, address or set or bound, expected miss pulses
  typedef struct packed {
    op_e         op;
    logic [15:0] arg;
    logic [1:0]  exp;
  } stim_t;

  // miss count left open, summed up for the next bound entry
  localparam logic [1:0] ANY = 2'd3;
  localparam int NUM_STIM = 33;
  localparam stim_t STIM [NUM_STIM] = '{
    '{OP_FETCH, 16'h1234, 2'd1}, '{OP_FETCH, 16'h1238, 2'd0}, '{OP_FETCH, 16'h1234, 2'd0},
    // four tags in set 5 fill the free ways
    '{OP_FETCH, 16'h2050, 2'd1}, '{OP_FETCH, 16'h3154, 2'd1}, '{OP_FETCH, 16'h4258, 2'd1},
    '{OP_FETCH, 16'h435C, 2'd1}, '{OP_FETCH, 16'h2050, 2'd0}, '{OP_FETCH, 16'h3154, 2'd0},
    '{OP_FETCH, 16'h4258, 2'd0}, '{OP_FETCH, 16'h435C, 2'd0},
    // fifth tag evicts, then a round over all five
    '{OP_FETCH, 16'h5550, 2'd1}, '{OP_FETCH, 16'h2050, ANY}, '{OP_FETCH, 16'h3154, ANY},
    '{OP_FETCH, 16'h4258, ANY}, '{OP_FETCH, 16'h435C, ANY}, '{OP_FETCH, 16'h5550, ANY},
    '{OP_BOUND, 16'd2, 2'd0},
    // set invalidation, other sets keep their lines
    '{OP_FETCH, 16'h7A7C, 2'd1}, '{OP_INV, 16'd5, 2'd0}, '{OP_FETCH, 16'h5550, 2'd1},
    '{OP_FETCH, 16'h1234, 2'd0}, '{OP_FETCH, 16'h7A7C, 2'd0},
    // flush drops everything
    '{OP_FLUSH, 16'd0, 2'd0}, '{OP_FETCH, 16'h1234, 2'd1}, '{OP_FETCH, 16'h5550, 2'd1},
    '{OP_FETCH, 16'h7A7C, 2'd1},
    // disabled cache, then back on
    '{OP_DIS, 16'd0, 2'd0}, '{OP_FETCH, 16'h1234, 2'd0}, '{OP_FETCH, 16'h7A7C, 2'd0},
    '{OP_EN, 16'd0, 2'd0}, '{OP_FETCH, 16'h1234, 2'd1}, '{OP_FETCH, 16'h1238, 2'd0}
  };

  logic                      clk_i;
  logic                      rst_ni;
  logic                      en_i;
  logic                      flush_i;
  logic                      fetch_req_i;
  logic [`ICACHE_ADDR_W-1:0] fetch_addr_i;
  logic                      fetch_ack_o;
  word_t                     fetch_data_o;
  logic                      refill_req_o;
  logic [`ICACHE_ADDR_W-1:0] refill_addr_o;
  logic                      refill_ack_i;
  line_t                     refill_line_i;
  logic                      inv_valid_i;
  index_t                    inv_index_i;
  logic                      miss_o;

  int errors;
  int miss_cnt;
  int refill_cnt;

  icache_top dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // memory model
  //////////////////////////////////////////////////

  // word value is a hash of its byte address
  function automatic word_t model_word(input logic [15:0] byte_addr);
    word_t a;
    a = {16'h0, byte_addr};
    return a * 32'h9E37 + 32'h1234;
  endfunction

  function automatic line_t model_line(input logic [15:0] base);
    line_t l;
    for (int i = 0; i < `ICACHE_LINE_W / `ICACHE_WORD_W; i++) begin
      l[i*`ICACHE_WORD_W +: `ICACHE_WORD_W] = model_word(base + 16'(4 * i));
    end
    return l;
  endfunction

  initial begin
    int delay;
    void'($urandom(11));
    refill_ack_i  = 1'b0;
    refill_line_i = '0;
    forever begin
      @(negedge clk_i);
      if (refill_req_o && !refill_ack_i) begin
        // request points at the start of the fetched line
        compare_value("refill_addr_o", 32'({fetch_addr_i[15:4], 4'h0}), 32'(refill_addr_o));
        delay = int'($urandom_range(5, 0));
        repeat (delay) @(negedge clk_i);
        refill_line_i = model_line(refill_addr_o);
        refill_ack_i  = 1'b1;
        refill_cnt++;
        // ack stays up until the cache lets go of its request
        do begin
          @(negedge clk_i);
        end while (refill_req_o);
        refill_ack_i = 1'b0;
      end
    end
  end

  // miss pulses, counted where they are stable
  always @(posedge clk_i) begin
    if (rst_ni && miss_o) begin
      miss_cnt++;
    end
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    if (act !== exp) begin
      errors++;
      $display("Error %0d ns: %s expected 0x%0h actual 0x%0h", $time, name, exp, act);
    end
  endtask

  // waits counts falling edges from request to ack, so 2 on a hit
  task automatic run_fetch(input logic [15:0] addr, output int waits);
    waits        = 0;
    fetch_addr_i = addr;
    fetch_req_i  = 1'b1;
    do begin
      @(negedge clk_i);
      waits++;
    end while (!fetch_ack_o);
    compare_value("fetch_data_o", model_word({addr[15:2], 2'b00}), fetch_data_o);
    fetch_req_i = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  initial begin
    stim_t ent;
    int    m0;
    int    r0;
    int    d_miss;
    int    d_ref;
    int    waits;
    int    free_miss;
    logic  cache_on;
    errors        = 0;
    miss_cnt      = 0;
    refill_cnt    = 0;
    free_miss     = 0;
    cache_on      = 1'b1;
    rst_ni        = 1'b0;
    en_i          = 1'b1;
    flush_i       = 1'b0;
    fetch_req_i   = 1'b0;
    fetch_addr_i  = '0;
    inv_valid_i   = 1'b0;
    inv_index_i   = '0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    for (int i = 0; i < NUM_STIM; i++) begin
      // previous handshake must be closed
      while (fetch_ack_o) @(negedge clk_i);
      ent = STIM[i];
      case (ent.op)
        OP_FETCH: begin
          m0 = miss_cnt;
          r0 = refill_cnt;
          run_fetch(ent.arg, waits);
          d_miss = miss_cnt - m0;
          d_ref  = refill_cnt - r0;
          if (!cache_on) begin
            compare_value("refill_req_o count", 1, d_ref);
            compare_value("miss_o pulses", 0, d_miss);
          end else begin
            if (ent.exp == ANY) begin
              // every miss is exactly one refill, hits none
              compare_value("refill_req_o count", d_miss, d_ref);
              free_miss += d_miss;
            end else begin
              compare_value("refill_req_o count", 32'(ent.exp), d_ref);
              compare_value("miss_o pulses", 32'(ent.exp), d_miss);
            end
            if (ent.exp == 2'd0) begin
              compare_value("fetch_ack_o latency", 2, waits);
            end
          end
        end
        OP_BOUND: begin
          compare_value("miss_o pulses above bound", 0, 32'(free_miss > int'(ent.arg)));
          free_miss = 0;
        end
        OP_FLUSH: begin
          flush_i = 1'b1;
          @(negedge clk_i);
          flush_i = 1'b0;
        end
        OP_INV: begin
          inv_index_i = ent.arg[3:0];
          inv_valid_i = 1'b1;
          @(negedge clk_i);
          inv_valid_i = 1'b0;
        end
        OP_EN, OP_DIS: begin
          cache_on = (ent.op == OP_EN);
          en_i     = cache_on;
          @(negedge clk_i);
        end
        default: begin
          errors++;
          $display("Stimulus entry %0d holds an unknown operation", i);
        end
      endcase
    end
    errors += dut.u_chk.fail_cnt;
    $display("Summary: %0d errors, %0d miss pulses, %0d refills", errors, miss_cnt, refill_cnt);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // generous bound per stimulus entry, flushes included
  initial begin
    repeat ((NUM_STIM + 1) * 200) @(posedge clk_i);
    $display("Timeout: the run did not finish within %0d cycles", (NUM_STIM + 1) * 200);
    $display("Checks failed");
    $finish;
  end

endmodule

/* icache_lite.f */
+incdir+rtl
rtl/icache_pkg.sv
rtl/icache_ctrl.sv
rtl/icache_tag_array.sv
rtl/icache_data_array.sv
rtl/icache_repl.sv
rtl/icache_top.sv
verif/icache_chk.sv
verif/icache_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := icache_tb
FILELIST  := icache_lite.f
BUILD_DIR := obj_dir
PASS_MSG  := All checks passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
